// File: common/noc_mesh_pkg.sv
//////////////////////////////////////////////////////////////////////
// Mesh coordinates, port indices and XY routing for the 5-port router
// Coordinates are 3 bits per axis, so a mesh holds at most 8x8 nodes
//////////////////////////////////////////////////////////////////////

package noc_mesh_pkg;

  localparam int NumPorts = 5;

  typedef struct packed {
    logic [2:0] x;
    logic [2:0] y;
  } xy_t;

  typedef enum logic [2:0] {
    PortNorth = 3'd0,
    PortSouth = 3'd1,
    PortWest  = 3'd2,
    PortEast  = 3'd3,
    PortLocal = 3'd4
  } port_e;

  // One-hot direction, bit i selects port i of port_e
  typedef logic [NumPorts-1:0] dir_oh_t;

  localparam dir_oh_t DirNorth = 5'b00001;
  localparam dir_oh_t DirSouth = 5'b00010;
  localparam dir_oh_t DirWest  = 5'b00100;
  localparam dir_oh_t DirEast  = 5'b01000;
  localparam dir_oh_t DirLocal = 5'b10000;

  // Direction the next router takes once the flit leaves through current.
  // North is toward smaller y, West toward smaller x
  function automatic dir_oh_t xy_route(xy_t position, xy_t destination, dir_oh_t current);
    xy_t next_pos;
    dir_oh_t route;
    next_pos = position;
    case (current)
      DirNorth: next_pos.y = position.y - 3'd1;
      DirSouth: next_pos.y = position.y + 3'd1;
      DirWest:  next_pos.x = position.x - 3'd1;
      DirEast:  next_pos.x = position.x + 3'd1;
      default:  next_pos = position;
    endcase
    // X first, then Y
    if (destination.x != next_pos.x) begin
      route = (destination.x > next_pos.x) ? DirEast : DirWest;
    end else if (destination.y != next_pos.y) begin
      route = (destination.y > next_pos.y) ? DirSouth : DirNorth;
    end else begin
      route = DirLocal;
    end
    return route;
  endfunction

endpackage

// File: common/noc_flit_pkg.sv
//////////////////////////////////////////////////////////////////////
// Flit format, a 2-bit preamble on top of a 32-bit data word
// The header layout must fill exactly one flit
//////////////////////////////////////////////////////////////////////

package noc_flit_pkg;

  localparam int DataWidth = 32;
  localparam int FlitWidth = DataWidth + 2;
  localparam int MsgWidth  = 4;

  // Reserved bits fill what remains of the data word
  localparam int ReservedWidth = DataWidth - 2 * $bits(noc_mesh_pkg::xy_t) - MsgWidth
                                 - $bits(noc_mesh_pkg::dir_oh_t);

  // Head and tail both set marks a single-flit packet
  typedef struct packed {
    logic head;
    logic tail;
  } preamble_t;

  typedef struct packed {
    preamble_t                preamble;
    noc_mesh_pkg::xy_t        source;
    noc_mesh_pkg::xy_t        destination;
    logic [MsgWidth-1:0]      message;
    logic [ReservedWidth-1:0] reserved;
    noc_mesh_pkg::dir_oh_t    routing;
  } header_t;

  // Same word seen as a routed header or as raw data
  typedef union packed {
    header_t              header;
    logic [FlitWidth-1:0] raw;
  } flit_t;

endpackage

// File: rtl/input_port/flit_fifo.sv
//////////////////////////////////////////////////////////////////////
// Circular flit buffer, Depth of 2 or more
// Empty FIFO passes the incoming flit to the head in the same cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module flit_fifo #(
  parameter int Depth = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                wr_i,
  input  noc_flit_pkg::flit_t data_i,
  input  logic                rd_i,
  output noc_flit_pkg::flit_t data_o,
  output logic                empty_o,
  output logic                full_o
);
  import noc_flit_pkg::*;

  localparam int PtrWidth = $clog2(Depth);
  localparam int CntWidth = $clog2(Depth + 1);

  flit_t               mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                stored_empty;
  logic                wr_ok;
  logic                rd_ok;
  logic                push;
  logic                pop;

  function automatic logic [PtrWidth-1:0] ptr_next(logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign stored_empty = (count_q == '0);
  assign full_o       = (count_q == CntWidth'(Depth));
  assign empty_o      = stored_empty & ~wr_i;
  assign data_o       = stored_empty ? data_i : mem_q[rd_ptr_q];

  assign wr_ok = wr_i & ~full_o;
  assign rd_ok = rd_i & ~empty_o;
  // A bypassed flit read in its arrival cycle is never stored
  assign push  = wr_ok & ~(rd_ok & stored_empty);
  assign pop   = rd_ok & ~stored_empty;

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: rtl/input_port/input_port.sv
//////////////////////////////////////////////////////////////////////
// One router input with its FIFO and look-ahead route computation
// stop_o follows FIFO full, a flit sent while stop_o is high is lost
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module input_port #(
  parameter int QueueDepth = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  noc_mesh_pkg::xy_t     position_i,
  input  noc_flit_pkg::flit_t   data_i,
  input  logic                  void_i,
  input  logic                  rd_en_i,
  output logic                  stop_o,
  output noc_flit_pkg::flit_t   fifo_head_o,
  output logic                  head_void_o,
  output noc_mesh_pkg::dir_oh_t request_o,
  output noc_mesh_pkg::dir_oh_t next_route_o
);
  import noc_mesh_pkg::*;

  dir_oh_t held_request_q;
  logic    valid_head;
  logic    tail_read;

  flit_fifo #(
    .Depth(QueueDepth)
  ) u_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr_i    (~void_i),
    .data_i  (data_i),
    .rd_i    (rd_en_i),
    .data_o  (fifo_head_o),
    .empty_o (head_void_o),
    .full_o  (stop_o)
  );

  assign valid_head = fifo_head_o.header.preamble.head & ~head_void_o;
  assign tail_read  = fifo_head_o.header.preamble.tail & ~head_void_o & rd_en_i;

  //////////////////////////////////////////////////////////////////////
  // Routing request of the current worm
  //////////////////////////////////////////////////////////////////////

  // Kept from the head until the tail has been read out
  always_ff @(posedge clk) begin
    if (rst) begin
      held_request_q <= '0;
    end else if (tail_read) begin
      held_request_q <= '0;
    end else if (valid_head) begin
      held_request_q <= fifo_head_o.header.routing;
    end
  end

  // A head at the FIFO output requests with its own routing field
  assign request_o = valid_head ? fifo_head_o.header.routing : held_request_q;

  // Look-ahead route, only meaningful while a head sits at the FIFO output
  assign next_route_o = xy_route(position_i, fifo_head_o.header.destination,
                                 fifo_head_o.header.routing);

endmodule

// File: rtl/switch/rr_arbiter.sv
//////////////////////////////////////////////////////////////////////
// Round-robin arbiter over the four inputs that may use one output
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rr_arbiter (
  input  logic       clk,
  input  logic       rst,
  input  logic [3:0] request_i,
  input  logic       advance_i,
  input  logic       hold_i,
  output logic [3:0] grant_o,
  output logic       grant_valid_o
);

  logic [1:0] ptr_q;
  logic [1:0] win_c;
  logic [1:0] win_q;
  logic [1:0] win;
  logic       found;
  logic [3:0] grant_c;
  logic [3:0] grant_q;

  // First request at or after the pointer
  always_comb begin
    logic [1:0] idx;
    found = 1'b0;
    win_c = ptr_q;
    for (int k = 0; k < 4; k++) begin
      idx = ptr_q + 2'(k);
      if (!found && request_i[idx]) begin
        found = 1'b1;
        win_c = idx;
      end
    end
  end

  assign grant_c       = found ? (4'b0001 << win_c) : 4'b0000;
  assign grant_o       = hold_i ? grant_q : grant_c;
  assign win           = hold_i ? win_q : win_c;
  assign grant_valid_o = |grant_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q   <= '0;
      win_q   <= '0;
      grant_q <= '0;
    end else begin
      win_q   <= win;
      grant_q <= grant_o;
      // Winner drops to lowest priority once its tail is out
      if (advance_i) begin
        ptr_q <= win + 2'd1;
      end
    end
  end

endmodule

// File: rtl/switch/output_port.sv
//////////////////////////////////////////////////////////////////////
// One router output, grant and selection held from head to tail
// Output flit and void flag are registered and frozen while stop_i
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module output_port (
  input  logic                clk,
  input  logic                rst,
  input  logic [3:0]          request_i,
  input  noc_flit_pkg::flit_t flit_i,
  input  logic                flit_void_i,
  input  logic                stop_i,
  output logic [3:0]          sel_o,
  output logic                insert_head_o,
  output logic                rd_o,
  output noc_flit_pkg::flit_t data_o,
  output logic                void_o
);

  typedef enum logic {
    StHead    = 1'b0,
    StPayload = 1'b1
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   hold;
  logic   grant_valid;
  logic   flit_ok;
  logic   fwd_head;
  logic   fwd_tail;

  // New grants only between worms and never while stalled
  assign hold = (state_q == StPayload) | stop_i;

  rr_arbiter u_arbiter (
    .clk           (clk),
    .rst           (rst),
    .request_i     (request_i),
    .advance_i     (fwd_tail),
    .hold_i        (hold),
    .grant_o       (sel_o),
    .grant_valid_o (grant_valid)
  );

  assign rd_o          = grant_valid & ~stop_i;
  assign flit_ok       = rd_o & ~flit_void_i;
  assign fwd_head      = flit_ok & flit_i.header.preamble.head;
  assign fwd_tail      = flit_ok & flit_i.header.preamble.tail;
  // Only the first flit of a worm gets the look-ahead route
  assign insert_head_o = (state_q == StHead);

  always_comb begin
    state_d = state_q;
    case (state_q)
      StHead: begin
        // Single-flit packet stays in head state
        if (fwd_head && !fwd_tail) begin
          state_d = StPayload;
        end
      end
      StPayload: begin
        if (fwd_tail) begin
          state_d = StHead;
        end
      end
      default: state_d = StHead;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= StHead;
      void_o  <= 1'b1;
    end else begin
      state_q <= state_d;
      if (!stop_i) begin
        void_o <= ~flit_ok;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (flit_ok) begin
      data_o <= flit_i;
    end
  end

endmodule

// File: rtl/switch/crossbar_switch.sv
//////////////////////////////////////////////////////////////////////
// Crossbar with one arbitrated output port per direction
// U-turns are never granted, each output sees the other four inputs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module crossbar_switch (
  input  logic                  clk,
  input  logic                  rst,
  input  noc_flit_pkg::flit_t   fifo_head_i [noc_mesh_pkg::NumPorts],
  input  logic [4:0]            head_void_i,
  input  noc_mesh_pkg::dir_oh_t request_i [noc_mesh_pkg::NumPorts],
  input  noc_mesh_pkg::dir_oh_t next_route_i [noc_mesh_pkg::NumPorts],
  input  logic [4:0]            stop_i,
  output noc_flit_pkg::flit_t   data_o [noc_mesh_pkg::NumPorts],
  output logic [4:0]            void_o,
  output logic [4:0]            rd_en_o
);
  import noc_mesh_pkg::*;
  import noc_flit_pkg::*;

  logic [NumPorts-1:0] rd_fan [NumPorts];

  // Input port behind arbiter slot, skipping the output's own port
  function automatic int other_input(int slot, int out_port);
    return (slot < out_port) ? slot : slot + 1;
  endfunction

  for (genvar o = 0; o < NumPorts; o++) begin : gen_out
    logic [NumPorts-2:0] req_sel;
    logic [NumPorts-2:0] sel;
    logic                insert_head;
    logic                rd;
    logic                flit_void;
    flit_t               flit_sel;
    flit_t               flit_fwd;
    dir_oh_t             route_sel;
    logic [NumPorts-1:0] rd_vec;

    // Transpose requests of the other inputs for this output
    always_comb begin
      req_sel = '0;
      for (int j = 0; j < NumPorts - 1; j++) begin
        req_sel[j] = request_i[other_input(j, o)][o];
      end
    end

    // Data multiplexer and read enable back to the granted input
    always_comb begin
      flit_sel  = '0;
      flit_void = 1'b1;
      route_sel = '0;
      rd_vec    = '0;
      for (int j = 0; j < NumPorts - 1; j++) begin
        if (sel[j]) begin
          flit_sel.raw                = fifo_head_i[other_input(j, o)].raw;
          flit_void                   = head_void_i[other_input(j, o)];
          route_sel                   = next_route_i[other_input(j, o)];
          rd_vec[other_input(j, o)]   = rd;
        end
      end
    end

    // Head flit leaves with the next router's direction
    always_comb begin
      flit_fwd = flit_sel;
      if (insert_head) begin
        flit_fwd.header.routing = route_sel;
      end
    end

    output_port u_output_port (
      .clk           (clk),
      .rst           (rst),
      .request_i     (req_sel),
      .flit_i        (flit_fwd),
      .flit_void_i   (flit_void),
      .stop_i        (stop_i[o]),
      .sel_o         (sel),
      .insert_head_o (insert_head),
      .rd_o          (rd),
      .data_o        (data_o[o]),
      .void_o        (void_o[o])
    );

    assign rd_fan[o] = rd_vec;
  end

  // An input is read by whichever output currently holds it
  always_comb begin
    rd_en_o = '0;
    for (int o = 0; o < NumPorts; o++) begin
      rd_en_o = rd_en_o | rd_fan[o];
    end
  end

endmodule

// File: rtl/router_top.sv
//////////////////////////////////////////////////////////////////////
// Five-port look-ahead XY mesh router with stop/void link control
// position_i must stay stable while traffic is in flight
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module router_top #(
  parameter int QueueDepth = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  noc_mesh_pkg::xy_t   position_i,
  input  noc_flit_pkg::flit_t data_n_i,
  input  noc_flit_pkg::flit_t data_s_i,
  input  noc_flit_pkg::flit_t data_w_i,
  input  noc_flit_pkg::flit_t data_e_i,
  input  noc_flit_pkg::flit_t data_p_i,
  input  logic [4:0]          data_void_i,
  output logic [4:0]          stop_o,
  output noc_flit_pkg::flit_t data_n_o,
  output noc_flit_pkg::flit_t data_s_o,
  output noc_flit_pkg::flit_t data_w_o,
  output noc_flit_pkg::flit_t data_e_o,
  output noc_flit_pkg::flit_t data_p_o,
  output logic [4:0]          data_void_o,
  input  logic [4:0]          stop_i
);
  import noc_mesh_pkg::*;
  import noc_flit_pkg::*;

  flit_t               data_in    [NumPorts];
  flit_t               fifo_head  [NumPorts];
  flit_t               data_out   [NumPorts];
  dir_oh_t             request    [NumPorts];
  dir_oh_t             next_route [NumPorts];
  logic [NumPorts-1:0] head_void;
  logic [NumPorts-1:0] rd_en;

  assign data_in[PortNorth] = data_n_i;
  assign data_in[PortSouth] = data_s_i;
  assign data_in[PortWest]  = data_w_i;
  assign data_in[PortEast]  = data_e_i;
  assign data_in[PortLocal] = data_p_i;

  assign data_n_o = data_out[PortNorth];
  assign data_s_o = data_out[PortSouth];
  assign data_w_o = data_out[PortWest];
  assign data_e_o = data_out[PortEast];
  assign data_p_o = data_out[PortLocal];

  for (genvar i = 0; i < NumPorts; i++) begin : gen_in
    input_port #(
      .QueueDepth(QueueDepth)
    ) u_input_port (
      .clk          (clk),
      .rst          (rst),
      .position_i   (position_i),
      .data_i       (data_in[i]),
      .void_i       (data_void_i[i]),
      .rd_en_i      (rd_en[i]),
      .stop_o       (stop_o[i]),
      .fifo_head_o  (fifo_head[i]),
      .head_void_o  (head_void[i]),
      .request_o    (request[i]),
      .next_route_o (next_route[i])
    );
  end

  crossbar_switch u_switch (
    .clk          (clk),
    .rst          (rst),
    .fifo_head_i  (fifo_head),
    .head_void_i  (head_void),
    .request_i    (request),
    .next_route_i (next_route),
    .stop_i       (stop_i),
    .data_o       (data_out),
    .void_o       (data_void_o),
    .rd_en_o      (rd_en)
  );

endmodule

// File: sim/router_cases.svh
//////////////////////////////////////////////////////////////////////
// Worm table for a router placed at (2,2), one row per worm
// Rows on one input go out in table order, a row waits for its port
//////////////////////////////////////////////////////////////////////

// Ports use the port_e numbering
// Stall bit k holds stop_i of out_port high in cycle start + k
typedef struct packed {
  logic [2:0]  in_port;
  logic [7:0]  start;
  logic [2:0]  dest_x;
  logic [2:0]  dest_y;
  logic [3:0]  length;
  logic [15:0] stall;
  logic [2:0]  out_port;
  logic [4:0]  route;
} case_t;

localparam int NumCases  = 12;
// Rows from here on carry a random payload
localparam int RandFirst = 10;

localparam case_t Cases [NumCases] = '{
  //  in   start  dest x/y    len    stall     out   look-ahead
  '{3'd4, 8'd0,  3'd4, 3'd2, 4'd4,  16'h0000, 3'd3, 5'b01000},
  '{3'd3, 8'd10, 3'd0, 3'd3, 4'd3,  16'h0000, 3'd2, 5'b00100},
  '{3'd2, 8'd20, 3'd2, 3'd4, 4'd5,  16'h0000, 3'd1, 5'b00010},
  '{3'd1, 8'd30, 3'd2, 3'd1, 4'd2,  16'h0000, 3'd0, 5'b10000},
  '{3'd0, 8'd40, 3'd2, 3'd2, 4'd1,  16'h0000, 3'd4, 5'b10000},
  // Three worms race for East
  '{3'd4, 8'd55, 3'd3, 3'd0, 4'd4,  16'h0000, 3'd3, 5'b00001},
  '{3'd2, 8'd55, 3'd3, 3'd2, 4'd3,  16'h0000, 3'd3, 5'b10000},
  '{3'd0, 8'd55, 3'd4, 3'd2, 4'd2,  16'h0000, 3'd3, 5'b01000},
  // Two worms race for West
  '{3'd3, 8'd75, 3'd1, 3'd4, 4'd3,  16'h0000, 3'd2, 5'b00010},
  '{3'd4, 8'd75, 3'd0, 3'd3, 4'd2,  16'h0000, 3'd2, 5'b00100},
  // Long stall on North fills the West input, short stall on South
  '{3'd2, 8'd95, 3'd2, 3'd0, 4'd10, 16'h3ffc, 3'd0, 5'b00001},
  '{3'd3, 8'd95, 3'd2, 3'd4, 4'd6,  16'h00f0, 3'd1, 5'b00010}
};

// File: sim/router_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the mesh router placed at (2,2) with 4-deep FIFOs
// An output flit counts as taken at a rising edge with stop_i low
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module router_tb;
  import noc_mesh_pkg::*;
  import noc_flit_pkg::*;

  `include "router_cases.svh"

  localparam int  ClkPeriod   = 40;
  localparam int  QueueDepth  = 4;
  localparam int  MaxLen      = 16;
  localparam int  WatchCycles = NumCases * 50;
  localparam xy_t Position    = '{x: 3'd2, y: 3'd2};

  logic                clk;
  logic                rst;
  flit_t               in_data  [NumPorts];
  flit_t               out_data [NumPorts];
  logic [NumPorts-1:0] data_void_i;
  logic [NumPorts-1:0] stop_o;
  logic [NumPorts-1:0] data_void_o;
  logic [NumPorts-1:0] stop_i;

  flit_t in_flit  [NumCases][MaxLen];
  flit_t out_flit [NumCases][MaxLen];
  logic  started  [NumCases];
  logic  done     [NumCases];
  int    head_cyc [NumCases];
  int    active   [NumPorts];
  int    sent     [NumPorts];
  int    cur_row  [NumPorts];
  int    idx      [NumPorts];
  logic  prev_stop [NumPorts];
  logic  prev_void [NumPorts];
  flit_t prev_data [NumPorts];
  string port_name [NumPorts] = '{"data_n_o", "data_s_o", "data_w_o", "data_e_o", "data_p_o"};

  int   cyc       = 0;
  int   errors    = 0;
  int   checks    = 0;
  int   delivered = 0;
  int   seed      = 66;
  logic running   = 1'b0;
  logic stop_seen = 1'b0;

  router_top #(
    .QueueDepth(QueueDepth)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .position_i  (Position),
    .data_n_i    (in_data[PortNorth]),
    .data_s_i    (in_data[PortSouth]),
    .data_w_i    (in_data[PortWest]),
    .data_e_i    (in_data[PortEast]),
    .data_p_i    (in_data[PortLocal]),
    .data_void_i (data_void_i),
    .stop_o      (stop_o),
    .data_n_o    (out_data[PortNorth]),
    .data_s_o    (out_data[PortSouth]),
    .data_w_o    (out_data[PortWest]),
    .data_e_o    (out_data[PortEast]),
    .data_p_o    (out_data[PortLocal]),
    .data_void_o (data_void_o),
    .stop_i      (stop_i)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [47:0] actual,
                             input logic [47:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Head carries the row in message and reserved, body flits a tagged counter
  task automatic build_flits();
    flit_t       f;
    int          len;
    logic [15:0] low;
    for (int r = 0; r < NumCases; r++) begin
      len = int'(Cases[r].length);
      f = '0;
      f.header.preamble.head = 1'b1;
      f.header.preamble.tail = (len == 1);
      f.header.source.x      = 3'(r);
      f.header.source.y      = Cases[r].in_port;
      f.header.destination.x = Cases[r].dest_x;
      f.header.destination.y = Cases[r].dest_y;
      f.header.message       = 4'(r);
      f.header.reserved      = ReservedWidth'(r);
      f.header.routing       = 5'b00001 << Cases[r].out_port;
      in_flit[r][0] = f;
      // Only the routing field changes on the way through
      f.header.routing = Cases[r].route;
      out_flit[r][0] = f;
      for (int k = 1; k < len; k++) begin
        if (r >= RandFirst) begin
          low = 16'($random(seed));
        end else begin
          low = 16'hc000 + 16'(k);
        end
        f = '0;
        f.header.preamble.tail = (k == len - 1);
        f.raw[DataWidth-1:0]   = {8'(r), 8'(k), low};
        in_flit[r][k]  = f;
        out_flit[r][k] = f;
      end
    end
  endtask

  function automatic int next_case(int p);
    for (int r = 0; r < NumCases; r++) begin
      if (!started[r] && int'(Cases[r].in_port) == p && int'(Cases[r].start) <= cyc) begin
        return r;
      end
    end
    return -1;
  endfunction

  task automatic drive_cycle();
    logic [NumPorts-1:0] void_v;
    logic [NumPorts-1:0] stop_v;
    int                  off;
    int                  r;
    void_v = '1;
    stop_v = '0;
    for (int k = 0; k < NumCases; k++) begin
      off = cyc - int'(Cases[k].start);
      if (off >= 0 && off < 16) begin
        if (Cases[k].stall[off]) begin
          stop_v[Cases[k].out_port] = 1'b1;
        end
      end
    end
    for (int p = 0; p < NumPorts; p++) begin
      if (active[p] < 0) begin
        active[p] = next_case(p);
        if (active[p] >= 0) begin
          started[active[p]] = 1'b1;
        end
      end
      r = active[p];
      // A new flit only while the input is not stopped
      if (r >= 0 && !stop_o[p]) begin
        in_data[p] = in_flit[r][sent[p]];
        void_v[p]  = 1'b0;
        sent[p]++;
        if (sent[p] == int'(Cases[r].length)) begin
          active[p] = -1;
          sent[p]   = 0;
        end
      end
    end
    data_void_i = void_v;
    stop_i      = stop_v;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitor
  //////////////////////////////////////////////////////////////////////

  task automatic finish_case(input int o);
    int r;
    r = cur_row[o];
    done[r] = 1'b1;
    delivered++;
    $display("case %0d: input %0d to %s, %0d flits, cycles %0d to %0d",
             r, Cases[r].in_port, port_name[o], Cases[r].length, head_cyc[r], cyc);
    cur_row[o] = -1;
  endtask

  task automatic observe_output(input int o);
    flit_t f;
    int    r;
    f = out_data[o];
    r = cur_row[o];
    if (!data_void_o[o] && !stop_i[o]) begin
      if (r < 0) begin
        r = int'(f.header.reserved);
        if (!f.header.preamble.head || r >= NumCases || int'(Cases[r].out_port) != o
            || done[r]) begin
          errors++;
          $display("Unexpected flit 0x%h on %s outside any expected worm", f.raw, port_name[o]);
        end else begin
          cur_row[o]  = r;
          idx[o]      = 0;
          head_cyc[r] = cyc;
        end
      end
      if (cur_row[o] >= 0) begin
        check_value($sformatf("%s case %0d flit %0d", port_name[o], r, idx[o]),
                    48'(f.raw), 48'(out_flit[r][idx[o]].raw));
        idx[o]++;
        if (idx[o] == int'(Cases[r].length)) begin
          finish_case(o);
        end
      end
    end else if (data_void_o[o] && !stop_i[o] && r >= 0) begin
      errors++;
      $display("Gap inside the worm of case %0d on %s", r, port_name[o]);
    end
  endtask

  // Outputs and stop_i are all stable at the falling edge
  always @(negedge clk) begin
    if (running) begin
      if (stop_o != '0) begin
        stop_seen = 1'b1;
      end
      for (int o = 0; o < NumPorts; o++) begin
        if (prev_stop[o]) begin
          check_value($sformatf("data_void_o[%0d] under stop_i", o),
                      48'(data_void_o[o]), 48'(prev_void[o]));
          check_value({port_name[o], " under stop_i"}, 48'(out_data[o].raw),
                      48'(prev_data[o].raw));
        end
        observe_output(o);
        prev_stop[o] = stop_i[o];
        prev_void[o] = data_void_o[o];
        prev_data[o] = out_data[o];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst         = 1'b1;
    data_void_i = '1;
    stop_i      = '0;
    for (int p = 0; p < NumPorts; p++) begin
      in_data[p]   = '0;
      active[p]    = -1;
      sent[p]      = 0;
      cur_row[p]   = -1;
      idx[p]       = 0;
      prev_stop[p] = 1'b0;
      prev_void[p] = 1'b1;
      prev_data[p] = '0;
    end
    for (int r = 0; r < NumCases; r++) begin
      started[r]  = 1'b0;
      done[r]     = 1'b0;
      head_cyc[r] = 0;
    end
    build_flits();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    check_value("stop_o", 48'(stop_o), 48'h0);
    check_value("data_void_o", 48'(data_void_o), 48'h1f);
    running = 1'b1;
    while (delivered < NumCases) begin
      drive_cycle();
      @(posedge clk);
      #1;
      cyc++;
    end
    data_void_i = '1;
    stop_i      = '0;
    // Idle cycles catch any flit delivered twice
    repeat (5) @(posedge clk);
    check_value("stop_o seen high", 48'(stop_seen), 48'h1);
    $display("%0d of %0d cases delivered, %0d checks, %0d errors",
             delivered, NumCases, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(WatchCycles * ClkPeriod);
    $display("Timeout: only %0d of %0d cases were delivered", delivered, NumCases);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: sim.f
+incdir+sim
common/noc_mesh_pkg.sv
common/noc_flit_pkg.sv
rtl/input_port/flit_fifo.sv
rtl/input_port/input_port.sv
rtl/switch/rr_arbiter.sv
rtl/switch/output_port.sv
rtl/switch/crossbar_switch.sv
rtl/router_top.sv
sim/router_tb.sv

// File: Makefile
# Verilator simulation of the mesh router

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the router testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module router_tb -f sim.f -Mdir obj_dir
	@out="$$(./obj_dir/Vrouter_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf obj_dir
